/* msx_cart_pkg.sv */
// ----------------------------
// shared widths, constants and the bus FSM encoding
// for the MSX cartridge I/O slice, imported by every module
// ----------------------------
`default_nettype none

package msx_cart_pkg;

	// ----------------------------
	// bus types
	// ----------------------------

	// Z80 I/O address as seen on ta
	typedef logic [7:0] io_addr_t;
	// one byte on td
	typedef logic [7:0] data_t;
	// PWM duty, out of 256
	typedef logic [7:0] level_t;

	// bus slave states
	typedef enum logic [1:0] {
		idle,
		read_wait,
		drive,
		hold
	} bus_state_t;

	// ----------------------------
	// constants
	// ----------------------------

	// gpio port address
	localparam io_addr_t GPIO_PORT = 8'h10;
	// twait length after reset, in clk cycles
	localparam logic [4:0] WAIT_CYCLES = 5'd16;
	// cycles a read may wait for read_ready before the slave gives up
	localparam logic [2:0] READ_TIMEOUT = 3'd4;
	// prescaler period, clk cycles per PWM tick (about 1 MHz)
	localparam logic [5:0] PWM_DIV = 6'd43;
	// tone half period in clk cycles
	localparam logic [25:0] TONE_HALF = 26'd61365;
	// duty during the high phase of the tone
	localparam level_t TONE_LEVEL = 8'hc0;
	// gpo bit that switches the tone on
	localparam int TONE_EN_BIT = 7;
	// strobe synchronizer depth
	localparam int SYNC_STAGES = 2;

endpackage

`default_nettype wire

/* msx_bus_slave.sv */
// ----------------------------
// MSX edge connector I/O slave: strobe sync, read/write pulses,
// td/tdir drive for reads and the power-on twait
// ----------------------------
`timescale 1ns/1ns
`default_nettype none

module msx_bus_slave import msx_cart_pkg::*; (
	input  logic       clk,
	input  logic       w_n_reset,
	input  logic       n_tiorq,
	input  logic       n_trd,
	input  logic       n_twr,
	input  io_addr_t   ta,
	inout  wire data_t td,
	output logic       tdir,
	output logic       twait,
	output io_addr_t   io_addr,
	output logic       io_read,
	output logic       io_write,
	output data_t      wdata,
	input  logic       read_ready,
	input  data_t      rdata
);

	// ----------------------------
	// strobe synchronizers
	// ----------------------------
	logic [SYNC_STAGES-1:0] iorq_sync;
	logic [SYNC_STAGES-1:0] rd_sync;
	logic [SYNC_STAGES-1:0] wr_sync;
	// synchronized strobes, still active low
	logic       iorq_s;
	logic       rd_s;
	logic       wr_s;
	// previous iorq for edge detect
	logic       iorq_prev;
	logic       iorq_fall;
	// one cycle after the falling edge is seen
	logic       cycle_start;
	bus_state_t state;
	logic [2:0] to_cnt;
	data_t      rd_latch;
	logic [4:0] wait_cnt;

	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			// idle bus is all high
			iorq_sync <= '1;
			rd_sync   <= '1;
			wr_sync   <= '1;
			iorq_prev <= 1'b1;
		end else begin
			iorq_sync <= {iorq_sync[SYNC_STAGES-2:0], n_tiorq};
			rd_sync   <= {rd_sync[SYNC_STAGES-2:0], n_trd};
			wr_sync   <= {wr_sync[SYNC_STAGES-2:0], n_twr};
			iorq_prev <= iorq_s;
		end
	end

	assign iorq_s    = iorq_sync[SYNC_STAGES-1];
	assign rd_s      = rd_sync[SYNC_STAGES-1];
	assign wr_s      = wr_sync[SYNC_STAGES-1];
	assign iorq_fall = iorq_prev & ~iorq_s;

	// ----------------------------
	// I/O pulses
	// ----------------------------
	// rd/wr are looked at one cycle after the iorq edge,
	// gives n_trd / n_twr some slack against n_tiorq
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			cycle_start <= 1'b0;
			io_read     <= 1'b0;
			io_write    <= 1'b0;
		end else begin
			cycle_start <= iorq_fall;
			io_read     <= cycle_start & ~rd_s;
			io_write    <= cycle_start & ~wr_s;
		end
	end

	// address and write data taken with the pulse
	always_ff @(posedge clk) begin
		if (cycle_start) begin
			io_addr <= ta;
			wdata   <= td;
		end
	end

	// ----------------------------
	// read FSM
	// ----------------------------
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			state  <= idle;
			to_cnt <= '0;
		end else begin
			case (state)
				idle: begin
					to_cnt <= '0;
					if (io_read) begin
						state <= read_wait;
					end
				end
				read_wait: begin
					// nobody decoded the address, give up
					if (read_ready) begin
						state <= drive;
					end else if (to_cnt == READ_TIMEOUT - 3'd1) begin
						state <= idle;
					end else begin
						to_cnt <= to_cnt + 3'd1;
					end
				end
				drive: begin
					// host done reading
					if (rd_s) begin
						state <= hold;
					end
				end
				hold: begin
					// wait for the end of the I/O cycle
					if (iorq_s) begin
						state <= idle;
					end
				end
				default: begin
					state <= idle;
				end
			endcase
		end
	end

	// read data for td
	always_ff @(posedge clk) begin
		if (state == read_wait && read_ready) begin
			rd_latch <= rdata;
		end
	end

	// tdir high means cartridge -> host
	assign tdir = (state == drive);
	assign td   = tdir ? rd_latch : 'z;

	// ----------------------------
	// power-on wait
	// ----------------------------
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			wait_cnt <= '0;
			twait    <= 1'b1;
		end else if (twait) begin
			// drops on the WAIT_CYCLES-th clock out of reset
			if (wait_cnt == WAIT_CYCLES - 5'd1) begin
				twait <= 1'b0;
			end
			wait_cnt <= wait_cnt + 5'd1;
		end
	end

endmodule

`default_nettype wire

/* gpio_port.sv */
// ----------------------------
// 8-bit GPIO at one I/O address
// reads give the dip switches, writes load the gpo register
// ----------------------------
`timescale 1ns/1ns
`default_nettype none

module gpio_port import msx_cart_pkg::*; (
	input  logic       clk,
	input  logic       w_n_reset,
	input  io_addr_t   io_addr,
	input  logic       io_read,
	input  logic       io_write,
	input  data_t      wdata,
	input  logic [4:0] dip_sw,
	output logic       read_ready,
	output data_t      rdata,
	output data_t      gpo
);

	// address decode
	logic addr_hit;

	assign addr_hit = (io_addr == GPIO_PORT);

	// ----------------------------
	// output register
	// ----------------------------
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			// pins low, tone off
			gpo <= '0;
		end else if (io_write && addr_hit) begin
			gpo <= wdata;
		end
	end

	// ----------------------------
	// switch read
	// ----------------------------
	// one cycle answer, only for our address
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			read_ready <= 1'b0;
		end else begin
			read_ready <= io_read & addr_hit;
		end
	end

	// top three bits read as zero
	always_ff @(posedge clk) begin
		if (io_read && addr_hit) begin
			rdata <= {3'b000, dip_sw};
		end
	end

endmodule

`default_nettype wire

/* tone_gen.sv */
// ----------------------------
// square wave test tone, gives a PWM level to the DAC
// ----------------------------
`timescale 1ns/1ns
`default_nettype none

module tone_gen import msx_cart_pkg::*; (
	input  logic   clk,
	input  logic   w_n_reset,
	input  logic   tone_en,
	output level_t level
);

	// half period counter
	logic [25:0] half_cnt;
	// current tone phase, 1 = high
	logic        phase;

	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			half_cnt <= '0;
			phase    <= 1'b0;
		end else if (!tone_en) begin
			// silent and restarted from the low phase
			half_cnt <= '0;
			phase    <= 1'b0;
		end else if (half_cnt == TONE_HALF - 26'd1) begin
			half_cnt <= '0;
			phase    <= ~phase;
		end else begin
			half_cnt <= half_cnt + 26'd1;
		end
	end

	// phase is already 0 while disabled
	assign level = phase ? TONE_LEVEL : '0;

endmodule

`default_nettype wire

/* pwm_dac.sv */
// ----------------------------
// 8-bit PWM sound output on tsnd
// ramp steps once per prescaler tick
// ----------------------------
`timescale 1ns/1ns
`default_nettype none

module pwm_dac import msx_cart_pkg::*; (
	input  logic   clk,
	input  logic   w_n_reset,
	input  level_t level,
	output logic   tsnd
);

	// prescaler, counts PWM_DIV-1 down to 0
	logic [5:0] pre_cnt;
	logic       tick;
	// 8-bit ramp
	logic [7:0] ramp;
	// level held for a whole ramp
	level_t     level_q;

	// ----------------------------
	// prescaler
	// ----------------------------
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			pre_cnt <= PWM_DIV - 6'd1;
		end else if (tick) begin
			pre_cnt <= PWM_DIV - 6'd1;
		end else begin
			pre_cnt <= pre_cnt - 6'd1;
		end
	end

	assign tick = (pre_cnt == 6'd0);

	// ----------------------------
	// ramp and compare
	// ----------------------------
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			ramp    <= '0;
			level_q <= '0;
			tsnd    <= 1'b0;
		end else begin
			if (tick) begin
				ramp <= ramp + 8'd1;
				// new level when the ramp wraps
				if (ramp == 8'hff) begin
					level_q <= level;
				end
			end
			// high for level_q ticks per ramp
			tsnd <= (ramp < level_q);
		end
	end

endmodule

`default_nettype wire

/* msx_cart_top.sv */
// ----------------------------
// MSX cartridge top: bus slave, GPIO, test tone and PWM sound
// ----------------------------
`timescale 1ns/1ns
`default_nettype none

module msx_cart_top import msx_cart_pkg::*; (
	input  logic       clk,
	input  logic       w_n_reset,
	// cartridge edge connector
	input  logic       n_tiorq,
	input  logic       n_trd,
	input  logic       n_twr,
	input  io_addr_t   ta,
	inout  wire data_t td,
	output logic       tdir,
	output logic       twait,
	output logic       tsnd,
	// board pins
	input  logic [4:0] dip_sw,
	output logic       sd_dat2,
	output logic       sd_dat3
);

	// ----------------------------
	// internal bus
	// ----------------------------
	io_addr_t io_addr;
	logic     io_read;
	logic     io_write;
	data_t    wdata;
	logic     read_ready;
	data_t    rdata;
	data_t    gpo;
	// tone path
	logic     tone_en;
	level_t   level;

	// gpo low bits go out on the spare sd pins
	assign sd_dat2 = gpo[0];
	assign sd_dat3 = gpo[1];
	assign tone_en = gpo[TONE_EN_BIT];

	// ----------------------------
	// bus slave
	// ----------------------------
	msx_bus_slave i_msx_bus_slave (
		.clk        (clk),
		.w_n_reset  (w_n_reset),
		.n_tiorq    (n_tiorq),
		.n_trd      (n_trd),
		.n_twr      (n_twr),
		.ta         (ta),
		.td         (td),
		.tdir       (tdir),
		.twait      (twait),
		.io_addr    (io_addr),
		.io_read    (io_read),
		.io_write   (io_write),
		.wdata      (wdata),
		.read_ready (read_ready),
		.rdata      (rdata)
	);

	// ----------------------------
	// gpio
	// ----------------------------
	gpio_port i_gpio_port (
		.clk        (clk),
		.w_n_reset  (w_n_reset),
		.io_addr    (io_addr),
		.io_read    (io_read),
		.io_write   (io_write),
		.wdata      (wdata),
		.dip_sw     (dip_sw),
		.read_ready (read_ready),
		.rdata      (rdata),
		.gpo        (gpo)
	);

	// ----------------------------
	// sound
	// ----------------------------
	tone_gen i_tone_gen (
		.clk       (clk),
		.w_n_reset (w_n_reset),
		.tone_en   (tone_en),
		.level     (level)
	);

	pwm_dac i_pwm_dac (
		.clk       (clk),
		.w_n_reset (w_n_reset),
		.level     (level),
		.tsnd      (tsnd)
	);

endmodule

`default_nettype wire

/* tb_checker.sv */
// ----------------------------
// testbench watcher that checks bus reads, gpo pins, twait and
// tone duty on the DUT pins and prints per-test lines and counts
// ----------------------------
`timescale 1ns/1ns
`default_nettype none

module tb_checker import msx_cart_pkg::*; (
	input  logic       clk,
	input  logic       n_tiorq,
	input  logic       n_trd,
	input  logic       n_twr,
	input  io_addr_t   ta,
	input  wire data_t td,
	input  logic       tdir,
	input  logic       twait,
	input  logic       tsnd,
	input  logic [4:0] dip_sw,
	input  logic       sd_dat2,
	input  logic       sd_dat3,
	// test number from the stimulus (7 ends the run)
	input  logic [2:0] test_id,
	output logic       meas_done,
	output logic       report_done,
	output int         error_count
);

	// limits in clk cycles
	localparam int TWAIT_LIMIT = 20;
	localparam int PIN_LIMIT   = 10;
	// low half period plus up to two PWM ramps
	localparam int RISE_LIMIT  = int'(TONE_HALF) + 2 * 256 * int'(PWM_DIV);
	localparam int TONE_WINDOW = 2 * int'(TONE_HALF);

	logic [2:0] cur_test;
	int         check_count;
	int         test_checks;
	int         test_errors;
	int         test_count;
	// read cycle being watched
	logic       in_rd;
	io_addr_t   rd_addr;
	data_t      rd_td;
	logic [4:0] rd_sw;
	logic       tdir_seen;
	// write cycle being watched
	logic       in_wr;
	io_addr_t   wr_addr;
	data_t      wr_data;
	// model of {sd_dat3, sd_dat2}
	logic [1:0] exp_pins;

	// ----------------------------
	// reference model
	// ----------------------------
	// td at the end of a read is undriven unless the gpio answers
	function automatic data_t expected_td(input io_addr_t addr, input logic [4:0] sw);
		if (addr == GPIO_PORT) begin
			return {3'b000, sw};
		end
		return 'z;
	endfunction

	function automatic string test_name(input logic [2:0] id);
		case (id)
			3'd1: return "power-on wait";
			3'd2: return "switch reads";
			3'd3: return "other addresses";
			3'd4: return "output register";
			3'd5: return "tone off";
			3'd6: return "tone on";
			default: return "unknown";
		endcase
	endfunction

	// ----------------------------
	// check helpers
	// ----------------------------
	task automatic check_value(input string name, input data_t got, input data_t exp);
		check_count++;
		test_checks++;
		if (got !== exp) begin
			error_count++;
			test_errors++;
			$display("** Error %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_true(input logic ok, input string what);
		check_count++;
		test_checks++;
		if (!ok) begin
			error_count++;
			test_errors++;
			$display("error: %s", what);
		end
	endtask

	task automatic report_test();
		test_count++;
		if (test_errors == 0) begin
			$display("test %0d %s: ok, %0d checks", cur_test, test_name(cur_test), test_checks);
		end else begin
			$display("test %0d %s: %0d of %0d checks wrong", cur_test, test_name(cur_test),
				test_errors, test_checks);
		end
	endtask

	// ----------------------------
	// per-test checks
	// ----------------------------
	task automatic check_power_on();
		int n;
		check_value("twait", {7'b0, twait}, 8'h01);
		check_value("tdir", {7'b0, tdir}, 8'h00);
		check_value("tsnd", {7'b0, tsnd}, 8'h00);
		n = 0;
		while (twait && n < TWAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		check_true(!twait, "twait still high 20 cycles after reset");
	endtask

	// pins settle a couple of clocks after io_write
	task automatic check_pins();
		int n;
		n = 0;
		while ({sd_dat3, sd_dat2} !== exp_pins && n < PIN_LIMIT) begin
			@(negedge clk);
			n++;
		end
		check_value("{sd_dat3,sd_dat2}", {6'b0, sd_dat3, sd_dat2}, {6'b0, exp_pins});
	endtask

	// high cycles of tsnd over one tone period
	task automatic measure_tone(input logic tone_on);
		int n;
		int high_cnt;
		int exp_high;
		int tol;
		n = 0;
		high_cnt = 0;
		if (tone_on) begin
			// window opens on the first high ramp
			while (!tsnd && n < RISE_LIMIT) begin
				@(negedge clk);
				n++;
			end
			check_true(tsnd, "tsnd never went high after the tone was switched on");
		end
		for (n = 0; n < TONE_WINDOW; n++) begin
			if (tsnd) begin
				high_cnt++;
			end
			@(negedge clk);
		end
		if (tone_on) begin
			// duty TONE_LEVEL/256 for half the period with 5 points of slack
			exp_high = TONE_WINDOW * int'(TONE_LEVEL) / 512;
			tol      = TONE_WINDOW * 5 / 100;
			check_true(high_cnt >= exp_high - tol && high_cnt <= exp_high + tol,
				$sformatf("tsnd high for %0d of %0d cycles, about %0d wanted",
				high_cnt, TONE_WINDOW, exp_high));
		end else begin
			check_true(high_cnt == 0,
				$sformatf("tsnd high for %0d cycles with the tone off", high_cnt));
		end
	endtask

	// one sample per clock for reads and writes
	task automatic watch_bus();
		data_t exp_td;
		if (!n_tiorq && !n_trd) begin
			in_rd   = 1'b1;
			rd_addr = ta;
			rd_td   = td;
			rd_sw   = dip_sw;
			if (tdir) begin
				tdir_seen = 1'b1;
			end
		end else if (in_rd) begin
			// strobe just rose so rd_td holds the last sample
			exp_td = expected_td(rd_addr, rd_sw);
			check_value("td", rd_td, exp_td);
			check_value("tdir", {7'b0, tdir_seen}, {7'b0, rd_addr == GPIO_PORT});
			in_rd     = 1'b0;
			tdir_seen = 1'b0;
		end
		if (!n_tiorq && !n_twr) begin
			in_wr   = 1'b1;
			wr_addr = ta;
			wr_data = td;
		end else if (in_wr) begin
			in_wr = 1'b0;
			if (wr_addr == GPIO_PORT) begin
				exp_pins = wr_data[1:0];
			end
			check_pins();
		end
	endtask

	// ----------------------------
	// compare process
	// ----------------------------
	// sampled on negedge where inputs and flops are settled
	initial begin
		error_count = 0;
		check_count = 0;
		meas_done   = 1'b0;
		report_done = 1'b0;
		cur_test    = 3'd0;
		test_checks = 0;
		test_errors = 0;
		test_count  = 0;
		in_rd       = 1'b0;
		in_wr       = 1'b0;
		tdir_seen   = 1'b0;
		exp_pins    = 2'b00;
		forever begin
			@(negedge clk);
			if (test_id != cur_test) begin
				if (cur_test != 3'd0) begin
					report_test();
				end
				cur_test    = test_id;
				test_checks = 0;
				test_errors = 0;
				meas_done   = 1'b0;
				case (cur_test)
					3'd1: check_power_on();
					3'd5: begin
						measure_tone(1'b0);
						meas_done = 1'b1;
					end
					3'd6: begin
						measure_tone(1'b1);
						meas_done = 1'b1;
					end
					3'd7: begin
						$display("tests %0d, checks %0d, errors %0d",
							test_count, check_count, error_count);
						report_done = 1'b1;
					end
					default: begin
					end
				endcase
			end else if (cur_test != 3'd0) begin
				watch_bus();
			end
		end
	end

endmodule

`default_nettype wire

/* tb_msx_cart.sv */
// ----------------------------
// testbench top with clock, reset, DUT, Z80 I/O cycles and test order
// checks live in tb_checker
// ----------------------------
`timescale 1ns/1ns
`default_nettype none

module tb_msx_cart import msx_cart_pkg::*; ();

	// bus timing in clk cycles
	localparam int STROBE_CYCLES = 8;
	localparam int GAP_CYCLES    = 2;
	// timeouts
	localparam int TWAIT_LIMIT   = 40;
	localparam int RELEASE_LIMIT = 10;
	localparam int MEAS_LIMIT    = 3 * int'(TONE_HALF) + 4 * 256 * int'(PWM_DIV);
	localparam int REPORT_LIMIT  = 10;
	localparam int SEED_INIT     = 32'h7e3a;

	logic       clk;
	logic       w_n_reset;
	logic       n_tiorq;
	logic       n_trd;
	logic       n_twr;
	io_addr_t   ta;
	wire data_t td;
	// host side of td
	data_t      td_out;
	logic       td_oe;
	logic       tdir;
	logic       twait;
	logic       tsnd;
	logic [4:0] dip_sw;
	logic       sd_dat2;
	logic       sd_dat3;
	// checker interface
	logic [2:0] test_id;
	logic       meas_done;
	logic       report_done;
	int         error_count;
	int         seed;

	assign td = td_oe ? td_out : 'z;

	msx_cart_top i_msx_cart_top (
		.clk       (clk),
		.w_n_reset (w_n_reset),
		.n_tiorq   (n_tiorq),
		.n_trd     (n_trd),
		.n_twr     (n_twr),
		.ta        (ta),
		.td        (td),
		.tdir      (tdir),
		.twait     (twait),
		.tsnd      (tsnd),
		.dip_sw    (dip_sw),
		.sd_dat2   (sd_dat2),
		.sd_dat3   (sd_dat3)
	);

	tb_checker i_tb_checker (
		.clk         (clk),
		.n_tiorq     (n_tiorq),
		.n_trd       (n_trd),
		.n_twr       (n_twr),
		.ta          (ta),
		.td          (td),
		.tdir        (tdir),
		.twait       (twait),
		.tsnd        (tsnd),
		.dip_sw      (dip_sw),
		.sd_dat2     (sd_dat2),
		.sd_dat3     (sd_dat3),
		.test_id     (test_id),
		.meas_done   (meas_done),
		.report_done (report_done),
		.error_count (error_count)
	);

	// 10 ns clock
	initial begin
		clk = 1'b0;
		forever begin
			#5;
			clk = ~clk;
		end
	end

	// ----------------------------
	// bus tasks
	// ----------------------------
	// inputs change 1 ns after the rising edge
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic stop_on_timeout(input string what);
		$display("timeout: %s", what);
		$display("** FAIL **");
		$finish;
	endtask

	task automatic wait_twait_low();
		int n;
		n = 0;
		while (twait && n < TWAIT_LIMIT) begin
			next_cycle();
			n++;
		end
		if (twait) begin
			stop_on_timeout("twait did not go low after reset");
		end
	endtask

	// slave leaves drive a few clocks after n_trd rises
	task automatic wait_bus_release();
		int n;
		n = 0;
		while (tdir && n < RELEASE_LIMIT) begin
			next_cycle();
			n++;
		end
		if (tdir) begin
			stop_on_timeout("tdir stayed high after the read ended");
		end
	endtask

	task automatic bus_read(input io_addr_t addr);
		ta      = addr;
		n_tiorq = 1'b0;
		n_trd   = 1'b0;
		repeat (STROBE_CYCLES) next_cycle();
		n_trd   = 1'b1;
		n_tiorq = 1'b1;
		wait_bus_release();
		repeat (GAP_CYCLES) next_cycle();
	endtask

	task automatic bus_write(input io_addr_t addr, input data_t data);
		ta      = addr;
		td_out  = data;
		td_oe   = 1'b1;
		n_tiorq = 1'b0;
		n_twr   = 1'b0;
		repeat (STROBE_CYCLES) next_cycle();
		n_twr   = 1'b1;
		n_tiorq = 1'b1;
		// data held one clock past the strobe
		next_cycle();
		td_oe = 1'b0;
		repeat (GAP_CYCLES) next_cycle();
	endtask

	// checker raises meas_done at the end of a tone window
	task automatic wait_measure();
		int n;
		n = 0;
		next_cycle();
		while (!meas_done && n < MEAS_LIMIT) begin
			next_cycle();
			n++;
		end
		if (!meas_done) begin
			stop_on_timeout("tone measurement did not finish");
		end
	endtask

	task automatic wait_report();
		int n;
		n = 0;
		while (!report_done && n < REPORT_LIMIT) begin
			next_cycle();
			n++;
		end
		if (!report_done) begin
			$display("timeout: checker gave no closing report");
		end
	endtask

	// ----------------------------
	// test sequence
	// ----------------------------
	initial begin
		int       rnd;
		int       i;
		io_addr_t addr;
		data_t    data;
		w_n_reset = 1'b0;
		n_tiorq   = 1'b1;
		n_trd     = 1'b1;
		n_twr     = 1'b1;
		ta        = '0;
		td_out    = '0;
		td_oe     = 1'b0;
		dip_sw    = '0;
		test_id   = 3'd0;
		seed      = SEED_INIT;
		// reset for 2 cycles
		repeat (2) @(posedge clk);
		#1;
		w_n_reset = 1'b1;

		// power-on wait
		test_id = 3'd1;
		wait_twait_low();
		repeat (GAP_CYCLES) next_cycle();

		// switch reads at the gpio address
		test_id = 3'd2;
		for (i = 0; i < 8; i++) begin
			rnd    = $random(seed);
			dip_sw = rnd[4:0];
			bus_read(GPIO_PORT);
		end

		// nobody answers here
		test_id = 3'd3;
		for (i = 0; i < 6; i++) begin
			rnd  = $random(seed);
			addr = rnd[7:0];
			if (addr == GPIO_PORT) begin
				addr = GPIO_PORT + 8'h01;
			end
			bus_read(addr);
		end

		// output register with each gpio write followed by a stray one
		test_id = 3'd4;
		for (i = 0; i < 8; i++) begin
			rnd  = $random(seed);
			data = rnd[7:0];
			// tone stays off until its own test
			data[TONE_EN_BIT] = 1'b0;
			bus_write(GPIO_PORT, data);
			rnd  = $random(seed);
			addr = rnd[7:0];
			if (addr == GPIO_PORT) begin
				addr = GPIO_PORT + 8'h01;
			end
			bus_write(addr, ~data);
		end
		bus_write(GPIO_PORT, 8'h00);

		// silence then tone
		test_id = 3'd5;
		wait_measure();
		rnd  = $random(seed);
		data = rnd[7:0];
		data[TONE_EN_BIT] = 1'b1;
		bus_write(GPIO_PORT, data);
		test_id = 3'd6;
		wait_measure();

		// closing report
		test_id = 3'd7;
		wait_report();
		if (report_done && error_count == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* msx_cart_top.f */
msx_cart_pkg.sv
msx_bus_slave.sv
gpio_port.sv
tone_gen.sv
pwm_dac.sv
msx_cart_top.sv
tb_checker.sv
tb_msx_cart.sv

/* Makefile */
# Verilator build and run for the MSX cartridge slice

VERILATOR ?= verilator
TOP       ?= tb_msx_cart
FLIST     ?= msx_cart_top.f
LOG       ?= sim.log
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FLIST)

run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q '\*\* PASS \*\*' $(LOG); then \
		echo "no result in $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)
